/* logic/conv_tile_defines.svh */
`ifndef CONV_TILE_DEFINES_SVH
`define CONV_TILE_DEFINES_SVH

////////////////////
// Array geometry
////////////////////

`define SA_ROWS 4   // Output-channel rows
`define ROW_W   2   // Row index width

////////////////////
// Data widths
////////////////////

`define DATA_W  8   // Signed pixel and weight
`define ACC_W   24  // Signed sum and bias
`define CNT_W   16  // Words per tile
`define SHIFT_W 4   // Quantize shift amount

`endif

/* logic/conv_tile_pkg.sv */
`default_nettype none
`include "conv_tile_defines.svh"

package conv_tile_pkg;

    // Controller phases
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_FEED  = 2'd1,  // Words streaming into the array
        CTRL_DRAIN = 2'd2   // Rows leaving through the post stages
    } ctrl_state_t;

    // Activation opcode
    typedef enum logic {
        POST_LINEAR = 1'b0,
        POST_RELU   = 1'b1
    } post_mode_t;

    typedef logic signed [`DATA_W-1:0] data_t;   // Pixel or weight
    typedef logic signed [`ACC_W-1:0]  acc_t;    // Row sum or bias
    typedef logic signed [7:0]         qdata_t;  // Quantized result
    typedef logic [`ROW_W-1:0]         row_idx_t;

endpackage

`default_nettype wire

/* logic/stage_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

// Strobes sent from the controller to one datapath stage.
// On the array bus clear means load the first word.
// On the post-stage buses clear flushes the stage register after a tile.
interface stage_ctrl_if import conv_tile_pkg::*; ();

    logic     en;     // Stage enable
    logic     clear;  // Load or flush strobe
    row_idx_t row;    // Row being drained
    logic     last;   // Last row of the tile

    modport ctrl (
        output en,
        output clear,
        output row,
        output last
    );

    modport stage (
        input en,
        input clear,
        input row,
        input last
    );

endinterface

`default_nettype wire

/* logic/sa_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module sa_ctrl import conv_tile_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire               start,
    input  wire [`CNT_W-1:0]  word_count,
    output logic              busy,
    stage_ctrl_if.ctrl        sa_bus,
    stage_ctrl_if.ctrl        bias_bus,
    stage_ctrl_if.ctrl        tail_bus
);

    ctrl_state_t       state;
    logic [`CNT_W-1:0] word_cnt;
    row_idx_t          row_cnt;
    logic              accept;
    logic              feed_en;
    logic              feed_last;
    logic              drain_run;
    logic              drain_last;

    // Strobes one cycle behind the drain
    logic              bias_en;
    logic              bias_last;
    logic              bias_clr;
    row_idx_t          bias_row;

    // Strobes two cycles behind the drain
    logic              tail_en;
    logic              tail_last;
    logic              tail_clr;
    row_idx_t          tail_row;

    ////////////////////
    // Word counter
    ////////////////////

    // Start cycle already carries word 0
    assign accept    = (state == CTRL_IDLE) && start && (word_count != '0);
    assign feed_en   = accept || (state == CTRL_FEED);
    assign feed_last = feed_en && (word_cnt == word_count - 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (feed_last) begin
            word_cnt <= '0;  // Ready for the next tile
        end else if (feed_en) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    ////////////////////
    // Row counter
    ////////////////////

    assign drain_last = drain_run && (row_cnt == row_idx_t'(`SA_ROWS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            drain_run <= 1'b0;
            row_cnt   <= '0;
        end else begin
            if (feed_last) begin
                drain_run <= 1'b1;
            end else if (drain_last) begin
                drain_run <= 1'b0;
            end
            if (drain_last) begin
                row_cnt <= '0;
            end else if (drain_run) begin
                row_cnt <= row_cnt + 1'b1;  // One row per clock
            end
        end
    end

    // FSM leaves drain when the last result reaches quantify
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CTRL_IDLE;
        end else begin
            case (state)
                CTRL_IDLE:  if (accept) state <= feed_last ? CTRL_DRAIN : CTRL_FEED;
                CTRL_FEED:  if (feed_last) state <= CTRL_DRAIN;
                CTRL_DRAIN: if (tail_clr) state <= CTRL_IDLE;
                default:    state <= CTRL_IDLE;
            endcase
        end
    end

    assign busy = (state != CTRL_IDLE);

    ////////////////////
    // Stage strobes
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bias_en   <= 1'b0;
            bias_last <= 1'b0;
            bias_clr  <= 1'b0;
            tail_en   <= 1'b0;
            tail_last <= 1'b0;
            tail_clr  <= 1'b0;
        end else begin
            bias_en   <= drain_run;
            bias_last <= drain_last;
            bias_clr  <= bias_last;  // Flush right after the last row
            tail_en   <= bias_en;
            tail_last <= bias_last;
            tail_clr  <= bias_clr;
        end
    end

    always_ff @(posedge clk) begin
        bias_row <= row_cnt;
        tail_row <= bias_row;
    end

    assign sa_bus.en      = feed_en;
    assign sa_bus.clear   = accept;     // First word loads
    assign sa_bus.row     = row_cnt;
    assign sa_bus.last    = drain_last;

    assign bias_bus.en    = bias_en;
    assign bias_bus.clear = bias_clr;
    assign bias_bus.row   = bias_row;
    assign bias_bus.last  = bias_last;

    assign tail_bus.en    = tail_en;
    assign tail_bus.clear = tail_clr;
    assign tail_bus.row   = tail_row;
    assign tail_bus.last  = tail_last;

endmodule

`default_nettype wire

/* logic/mac_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module mac_array import conv_tile_pkg::*; (
    input  wire                        clk,
    input  wire data_t                 in_pixel,
    input  wire data_t [`SA_ROWS-1:0]  in_weights,
    stage_ctrl_if.stage                sa_bus,
    output acc_t                       acc_out
);

    // Row sums gathered for the drain mux
    acc_t row_sum [`SA_ROWS];

    ////////////////////
    // MAC rows
    ////////////////////

    for (genvar r = 0; r < `SA_ROWS; r++) begin : g_row
        acc_t prod;
        acc_t acc_q;

        // Same pixel to every row, own weight per row
        assign prod = acc_t'(in_pixel) * acc_t'(in_weights[r]);

        always_ff @(posedge clk) begin
            if (sa_bus.en) begin
                if (sa_bus.clear) begin
                    acc_q <= prod;          // Word 0 of a tile
                end else begin
                    acc_q <= acc_q + prod;
                end
            end
        end

        assign row_sum[r] = acc_q;
    end

    ////////////////////
    // Drain select
    ////////////////////

    // Row index is only meaningful while draining
    always_ff @(posedge clk) begin
        if (!sa_bus.en) begin
            acc_out <= row_sum[sa_bus.row];
        end
    end

endmodule

`default_nettype wire

/* logic/add_bias.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module add_bias import conv_tile_pkg::*; (
    input  wire                        clk,
    input  wire acc_t [`SA_ROWS-1:0]   biases,
    input  wire acc_t                  acc_in,
    stage_ctrl_if.stage                bias_bus,
    output acc_t                       acc_out
);

    acc_t row_bias;
    acc_t biased;

    // Bias of the row now on the bus
    assign row_bias = biases[bias_bus.row];
    assign biased   = acc_in + row_bias;

    always_ff @(posedge clk) begin
        if (bias_bus.clear) begin
            acc_out <= '0;      // Tile done
        end else if (bias_bus.en) begin
            acc_out <= biased;
        end
    end

endmodule

`default_nettype wire

/* logic/e_tail.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module e_tail import conv_tile_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire post_mode_t   mode,
    input  wire acc_t         acc_in,
    stage_ctrl_if.stage       tail_bus,
    output acc_t              acc_out,
    output logic              q_en,
    output row_idx_t          q_row,
    output logic              q_last
);

    logic is_neg;
    acc_t tail_val;

    assign is_neg   = acc_in[`ACC_W-1];
    assign tail_val = (mode == POST_RELU && is_neg) ? '0 : acc_in;  // ReLU clamp

    always_ff @(posedge clk) begin
        if (tail_bus.clear) begin
            acc_out <= '0;
        end else if (tail_bus.en) begin
            acc_out <= tail_val;
        end
    end

    ////////////////////
    // Quantify strobes
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            q_en   <= 1'b0;
            q_last <= 1'b0;
        end else begin
            q_en   <= tail_bus.en;
            q_last <= tail_bus.last;
        end
    end

    always_ff @(posedge clk) begin
        q_row <= tail_bus.row;
    end

endmodule

`default_nettype wire

/* logic/quantify.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module quantify import conv_tile_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire [`SHIFT_W-1:0]  quant_shift,
    input  wire acc_t           acc_in,
    input  wire                 q_en,
    input  wire row_idx_t       q_row,
    input  wire                 q_last,
    output logic                out_valid,
    output row_idx_t            out_row,
    output qdata_t              out_data,
    output logic                out_last
);

    // Signed byte limits
    localparam acc_t SAT_HI = acc_t'(127);
    localparam acc_t SAT_LO = acc_t'(-128);

    acc_t   shifted;
    qdata_t sat;

    always_comb begin
        shifted = acc_in >>> quant_shift;   // Keeps the sign
        if (shifted > SAT_HI) begin
            sat = qdata_t'(SAT_HI);
        end else if (shifted < SAT_LO) begin
            sat = qdata_t'(SAT_LO);
        end else begin
            sat = qdata_t'(shifted);
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= q_en;
            out_last  <= q_last && q_en;
        end
    end

    always_ff @(posedge clk) begin
        if (q_en) begin
            out_row  <= q_row;
            out_data <= sat;
        end
    end

endmodule

`default_nettype wire

/* logic/conv_tile_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module conv_tile_top import conv_tile_pkg::*; (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire data_t                 in_pixel,
    input  wire data_t [`SA_ROWS-1:0]  in_weights,
    input  wire [`CNT_W-1:0]           word_count,
    input  wire post_mode_t            mode,
    input  wire [`SHIFT_W-1:0]         quant_shift,
    input  wire acc_t [`SA_ROWS-1:0]   biases,
    output logic                       busy,
    output logic                       out_valid,
    output row_idx_t                   out_row,
    output qdata_t                     out_data,
    output logic                       out_last
);

    // Controller to stage strobe buses
    stage_ctrl_if sa_bus ();
    stage_ctrl_if bias_bus ();
    stage_ctrl_if tail_bus ();

    acc_t     mac_sum;    // Drained row sum
    acc_t     bias_sum;
    acc_t     tail_sum;
    logic     q_en;
    row_idx_t q_row;
    logic     q_last;

    sa_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .word_count (word_count),
        .busy       (busy),
        .sa_bus     (sa_bus.ctrl),
        .bias_bus   (bias_bus.ctrl),
        .tail_bus   (tail_bus.ctrl)
    );

    mac_array u_mac (
        .clk        (clk),
        .in_pixel   (in_pixel),
        .in_weights (in_weights),
        .sa_bus     (sa_bus.stage),
        .acc_out    (mac_sum)
    );

    add_bias u_bias (
        .clk        (clk),
        .biases     (biases),
        .acc_in     (mac_sum),
        .bias_bus   (bias_bus.stage),
        .acc_out    (bias_sum)
    );

    e_tail u_tail (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .acc_in     (bias_sum),
        .tail_bus   (tail_bus.stage),
        .acc_out    (tail_sum),
        .q_en       (q_en),
        .q_row      (q_row),
        .q_last     (q_last)
    );

    quantify u_quant (
        .clk         (clk),
        .reset       (reset),
        .quant_shift (quant_shift),
        .acc_in      (tail_sum),
        .q_en        (q_en),
        .q_row       (q_row),
        .q_last      (q_last),
        .out_valid   (out_valid),
        .out_row     (out_row),
        .out_data    (out_data),
        .out_last    (out_last)
    );

endmodule

`default_nettype wire

/* sim/tb_conv_tile_tasks.svh */
`ifndef TB_CONV_TILE_TASKS_SVH
`define TB_CONV_TILE_TASKS_SVH

////////////////////
// Compare tasks
////////////////////

task automatic check_qdata(input string what, input qdata_t got, input qdata_t exp);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", what, got, exp);
        errors++;
    end
endtask

task automatic check_row(input string what, input row_idx_t got, input row_idx_t exp);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", what, got, exp);
        errors++;
    end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        $display("CHECK FAILED %s: got 0x%h expected 0x%h", what, got, exp);
        errors++;
    end
endtask

// One line per finished test
task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
        $display("%-20s ok", name);
    end else begin
        tests_failed++;
        $display("%-20s failed with %0d errors", name, errors - errs_before);
    end
endtask

////////////////////
// Reference model
////////////////////

// Dot product, bias, activation, shift, clamp to a signed byte
function automatic qdata_t expected_row(input int r);
    longint sum;
    int     i;
    sum = 0;
    for (i = 0; i < tile_n; i++) begin
        sum += longint'(tile_pix[i]) * longint'(tile_wgt[i][r]);
    end
    sum += longint'(tile_bias[r]);
    if (tile_mode == POST_RELU && sum < 0) begin
        sum = 0;
    end
    sum = sum >>> tile_shift;
    if (sum > 127) begin
        return 8'sd127;
    end
    if (sum < -128) begin
        return -8'sd128;
    end
    return qdata_t'(sum);
endfunction

////////////////////
// Driver and monitor
////////////////////

// Word 0 goes out with start, the rest follow with no gap
task automatic run_tile(input logic extra_start, output int start_cyc);
    int i;
    int r;
    @(posedge clk);
    #1;
    start_cyc   = cycle;
    word_count  = tile_n[`CNT_W-1:0];
    mode        = tile_mode;
    quant_shift = tile_shift;
    for (r = 0; r < `SA_ROWS; r++) begin
        biases[r] = tile_bias[r];
    end
    start = 1'b1;
    for (i = 0; i < tile_n; i++) begin
        if (i > 0) begin
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        in_pixel = tile_pix[i];
        for (r = 0; r < `SA_ROWS; r++) begin
            in_weights[r] = tile_wgt[i][r];
        end
    end
    @(posedge clk);
    #1;
    start      = extra_start;  // Lands while the tile drains
    in_pixel   = '0;
    in_weights = '0;
    @(posedge clk);
    #1;
    start = 1'b0;
endtask

// Row r is due N + 4 + r cycles after start was driven
task automatic wait_outputs(input int start_cyc);
    int idx;
    int waited;
    int limit;
    int due;
    idx    = 0;
    waited = 0;
    limit  = tile_n + `SA_ROWS + 20;
    while (idx < `SA_ROWS && waited < limit) begin
        @(negedge clk);
        waited++;
        if (out_valid) begin
            due = start_cyc + tile_n + 4 + idx;
            check_row("out_row", out_row, row_idx_t'(idx));
            check_qdata($sformatf("out_data row %0d", idx), out_data, expected_row(idx));
            check_flag("out_last", out_last, idx == `SA_ROWS - 1);
            if (cycle != due) begin
                $display("row %0d came out at cycle %0d, due at cycle %0d", idx, cycle, due);
                errors++;
            end
            // Busy drops together with the last row
            check_flag("busy", busy, idx != `SA_ROWS - 1);
            idx++;
        end
    end
    if (idx < `SA_ROWS) begin
        $display("timed out waiting for row %0d of the tile", idx);
        errors++;
    end
endtask

task automatic run_and_check(input logic extra_start);
    int start_cyc;
    run_tile(extra_start, start_cyc);
    wait_outputs(start_cyc);
endtask

`endif

/* sim/tb_conv_tile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_tile_defines.svh"

module tb_conv_tile import conv_tile_pkg::*; ();

    localparam int MAX_WORDS = 64;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 start;
    data_t                in_pixel;
    data_t [`SA_ROWS-1:0] in_weights;
    logic [`CNT_W-1:0]    word_count;
    post_mode_t           mode;
    logic [`SHIFT_W-1:0]  quant_shift;
    acc_t [`SA_ROWS-1:0]  biases;
    logic                 busy;
    logic                 out_valid;
    row_idx_t             out_row;
    qdata_t               out_data;
    logic                 out_last;

    // Tile under test, shared by driver and model
    int                   tile_n;
    data_t                tile_pix [MAX_WORDS];
    data_t                tile_wgt [MAX_WORDS][`SA_ROWS];
    acc_t                 tile_bias [`SA_ROWS];
    post_mode_t           tile_mode;
    logic [`SHIFT_W-1:0]  tile_shift;

    int cycle        = 0;
    int errors       = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    always #2 clk = ~clk;  // 4 ns period

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    conv_tile_top uut (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .in_pixel    (in_pixel),
        .in_weights  (in_weights),
        .word_count  (word_count),
        .mode        (mode),
        .quant_shift (quant_shift),
        .biases      (biases),
        .busy        (busy),
        .out_valid   (out_valid),
        .out_row     (out_row),
        .out_data    (out_data),
        .out_last    (out_last)
    );

    `include "tb_conv_tile_tasks.svh"

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic idle_after_reset();
        int errs_before;
        int i;
        errs_before = errors;
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("out_last", out_last, 1'b0);
        end
        report_test("idle after reset", errs_before);
    endtask

    task automatic linear_tile();
        int errs_before;
        int i;
        int r;
        errs_before = errors;
        tile_n     = 4;
        tile_mode  = POST_LINEAR;
        tile_shift = '0;
        for (i = 0; i < tile_n; i++) begin
            tile_pix[i] = data_t'(i + 1);
            for (r = 0; r < `SA_ROWS; r++) begin
                tile_wgt[i][r] = data_t'((r + 1) * (i + 1) - 3);
            end
        end
        for (r = 0; r < `SA_ROWS; r++) begin
            tile_bias[r] = acc_t'(r * 7 - 9);
        end
        run_and_check(1'b0);
        report_test("linear tile", errs_before);
    endtask

    // Odd rows end up negative and clamp to zero
    task automatic relu_tile();
        int errs_before;
        int r;
        errs_before = errors;
        tile_n      = 3;
        tile_mode   = POST_RELU;
        tile_shift  = '0;
        tile_pix[0] = 8'sd5;
        tile_pix[1] = -8'sd3;
        tile_pix[2] = 8'sd2;
        for (r = 0; r < `SA_ROWS; r++) begin
            tile_wgt[0][r] = data_t'((r % 2 == 0) ? 4 + r : -4 - r);
            tile_wgt[1][r] = tile_wgt[0][r];
            tile_wgt[2][r] = tile_wgt[0][r];
            tile_bias[r]   = acc_t'(r - 1);
        end
        run_and_check(1'b0);
        report_test("relu tile", errs_before);
    endtask

    task automatic shift_saturation();
        int    errs_before;
        int    i;
        int    r;
        data_t sat_wgt [4];
        errs_before = errors;
        sat_wgt     = '{8'sd127, -8'sd128, 8'sd1, -8'sd1};  // High, low, two mid-range
        tile_n      = 8;
        tile_mode   = POST_LINEAR;
        tile_shift  = 4'd4;
        for (i = 0; i < tile_n; i++) begin
            tile_pix[i] = 8'sd127;
            for (r = 0; r < `SA_ROWS; r++) begin
                tile_wgt[i][r] = sat_wgt[r % 4];
            end
        end
        for (r = 0; r < `SA_ROWS; r++) begin
            tile_bias[r] = (r == 3) ? -24'sd7 : 24'sd0;
        end
        run_and_check(1'b0);
        report_test("shift and saturate", errs_before);
    endtask

    task automatic random_tiles();
        int errs_before;
        int t;
        int i;
        int r;
        errs_before = errors;
        for (t = 0; t < 8; t++) begin
            tile_n     = $urandom_range(40, 1);
            tile_mode  = post_mode_t'($urandom_range(1, 0));
            tile_shift = $urandom_range(12, 4);
            for (i = 0; i < tile_n; i++) begin
                tile_pix[i] = data_t'($urandom);
                for (r = 0; r < `SA_ROWS; r++) begin
                    tile_wgt[i][r] = data_t'($urandom);
                end
            end
            for (r = 0; r < `SA_ROWS; r++) begin
                tile_bias[r] = acc_t'(int'($urandom_range(131071, 0)) - 65536);
            end
            run_and_check(1'b1);  // Extra start pulse in the drain
        end
        report_test("random tiles", errs_before);
    endtask

    task automatic zero_count_start();
        int errs_before;
        int i;
        errs_before = errors;
        @(posedge clk);
        #1;
        word_count = '0;
        start      = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        start = 1'b0;
        for (i = 0; i < 30; i++) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
        end
        report_test("zero word count", errs_before);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int seed_ret;
        seed_ret    = $urandom(32'h34a30d8d);
        reset       = 1'b1;
        start       = 1'b0;
        in_pixel    = '0;
        in_weights  = '0;
        word_count  = '0;
        mode        = POST_LINEAR;
        quant_shift = '0;
        biases      = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        idle_after_reset();
        linear_tile();
        relu_tile();
        shift_saturation();
        random_tiles();
        zero_count_start();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* conv_tile.f */
+incdir+logic
+incdir+sim
logic/conv_tile_pkg.sv
logic/stage_ctrl_if.sv
logic/sa_ctrl.sv
logic/mac_array.sv
logic/add_bias.sv
logic/e_tail.sv
logic/quantify.sv
logic/conv_tile_top.sv
sim/tb_conv_tile.sv
